/* tb.f */
+incdir+logic
logic/usb_out_pkg.sv
logic/usb_out_cfg_if.sv
logic/usb_out_ep_regs.sv
logic/usb_out_xact_engine.sv
logic/usb_out_rx_capture.sv
logic/usb_out_top.sv
verification/usb_out_props.sv
verification/usb_out_checker.sv
verification/tb_usb_out.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_usb_out

SRCS := $(shell grep -v '^+' tb.f) logic/usb_out_settings.svh
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) tb.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f tb.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'ALL CHECKS PASSED'

clean:
	rm -rf obj_dir

/* verification/tb_usb_out.sv */
// Testbench for the USB OUT/SETUP engine
// Drives AXI4-Lite setup and USB packets, predicts handshakes and toggles

`timescale 1ns/1ps
`include "usb_out_settings.svh"

module tb_usb_out import usb_out_pkg::*; ();

  localparam int unsigned MAX_CYCLES = 20000;

  logic clk_48mhz_i = 1'b0;
  logic rst_ni = 1'b0;
  logic link_reset_i = 1'b0;
  logic [4:0] awaddr_i = '0, araddr_i = '0;
  logic [31:0] wdata_i = '0, rdata_o;
  logic awvalid_i = 1'b0, wvalid_i = 1'b0, bready_i = 1'b0, arvalid_i = 1'b0, rready_i = 1'b0;
  logic awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
  logic [1:0] bresp_o, rresp_o;
  logic rx_pkt_start_i = 1'b0, rx_pkt_end_i = 1'b0, rx_pkt_valid_i = 1'b0;
  usb_pid_e rx_pid_i = PidOut;
  logic [6:0] rx_addr_i = '0;
  logic [3:0] rx_endp_i = '0;
  logic rx_data_put_i = 1'b0;
  logic [7:0] rx_data_i = '0;
  logic tx_pkt_start_o, out_ep_newpkt_o, out_ep_data_put_o, out_ep_acked_o, out_ep_rollback_o;
  usb_pid_e tx_pid_o;
  ep_idx_t out_ep_current_o;
  put_addr_t out_ep_put_addr_o;
  logic [7:0] out_ep_data_o;
  ep_mask_t out_ep_setup_o;
  ep_mask_t out_ep_full_i = '0;

  // Software-visible model
  logic [6:0] dev_m = '0;
  ep_mask_t en_m = '0, ctl_m = '0, stall_m = '0, tog_m = '0, setup_m = '0;
  int unsigned tb_errors = 0;
  int unsigned cycles = 0;

  usb_out_top i_usb_out_top (.*);

  usb_out_checker i_checker (
    .clk_48mhz_i, .rst_ni, .tx_pkt_start_i (tx_pkt_start_o), .tx_pid_i (tx_pid_o),
    .newpkt_i (out_ep_newpkt_o), .current_i (out_ep_current_o),
    .data_put_i (out_ep_data_put_o),
    .put_addr_i (out_ep_put_addr_o), .data_i (out_ep_data_o),
    .acked_i (out_ep_acked_o), .rollback_i (out_ep_rollback_o), .setup_i (out_ep_setup_o)
  );

  always #50 clk_48mhz_i = ~clk_48mhz_i;

  // Run limit
  always @(posedge clk_48mhz_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////
  // Returns {tx, pid, acked, rollback} for a data packet that was accepted
  function automatic logic [6:0] ref_response(input logic is_setup, input logic tog_ok,
                                              input logic full, input logic stall);
    if (!tog_ok && !stall) return {1'b1, PidAck, 2'b01};
    if (is_setup) return full ? {1'b0, PidAck, 2'b01} : {1'b1, PidAck, 2'b10};
    if (stall) return {1'b1, PidStall, 2'b00};
    if (full) return {1'b1, PidNak, 2'b01};
    return {1'b1, PidAck, 2'b10};
  endfunction

  task automatic step();
    @(posedge clk_48mhz_i);
    #1;
  endtask

  task automatic axi_write(input logic [4:0] addr, input logic [31:0] data);
    int n;
    awaddr_i = addr;
    wdata_i = data;
    awvalid_i = 1'b1;
    wvalid_i = 1'b1;
    n = 0;
    do begin
      @(negedge clk_48mhz_i);
      n++;
    end while (!awready_o && n < 50);
    if (!awready_o) begin
      tb_errors++;
      $display("AXI write to %h was never accepted", addr);
    end
    step();
    awvalid_i = 1'b0;
    wvalid_i = 1'b0;
    bready_i = 1'b1;
    n = 0;
    while (!bvalid_o && n < 50) begin
      @(negedge clk_48mhz_i);
      n++;
    end
    if (!bvalid_o) begin
      tb_errors++;
      $display("AXI write response missing for %h", addr);
    end else if (bresp_o != 2'b00) begin
      tb_errors++;
      $display("Mismatch at %0t: write to %h responds %b, expected OKAY", $time, addr, bresp_o);
    end
    step();
    bready_i = 1'b0;
  endtask

  task automatic check_reg(input logic [4:0] addr, input logic [31:0] exp);
    int n;
    logic [31:0] got;
    araddr_i = addr;
    arvalid_i = 1'b1;
    n = 0;
    do begin
      @(negedge clk_48mhz_i);
      n++;
    end while (!arready_o && n < 50);
    step();
    arvalid_i = 1'b0;
    rready_i = 1'b1;
    n = 0;
    do begin
      @(negedge clk_48mhz_i);
      n++;
    end while (!rvalid_o && n < 50);
    got = rdata_o;
    if (!rvalid_o) begin
      tb_errors++;
      $display("AXI read of %h got no data", addr);
    end else if (got != exp) begin
      tb_errors++;
      $display("Mismatch at %0t: reg %h reads %h, expected %h", $time, addr, got, exp);
    end
    if (rvalid_o && rresp_o != 2'b00) begin
      tb_errors++;
      $display("Mismatch at %0t: read of %h responds %b, expected OKAY", $time, addr, rresp_o);
    end
    step();
    rready_i = 1'b0;
  endtask

  task automatic send_token(input usb_pid_e pid, input logic [6:0] addr, input logic [3:0] ep);
    rx_pkt_end_i = 1'b1;
    rx_pkt_valid_i = 1'b1;
    rx_pid_i = pid;
    rx_addr_i = addr;
    rx_endp_i = ep;
    step();
    rx_pkt_end_i = 1'b0;
    rx_pkt_valid_i = 1'b0;
  endtask

  task automatic send_data(input usb_pid_e pid, input int len, input logic expect_puts);
    logic [7:0] b;
    rx_pkt_start_i = 1'b1;
    step();
    rx_pkt_start_i = 1'b0;
    for (int i = 0; i < len; i++) begin
      b = 8'($urandom);
      rx_data_put_i = 1'b1;
      rx_data_i = b;
      if (expect_puts) i_checker.push_put(put_addr_t'(i > 31 ? 31 : i), b);
      step();
    end
    rx_data_put_i = 1'b0;
    repeat (2) step();
    send_token(pid, 7'h0, 4'h0);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    do begin
      @(negedge clk_48mhz_i);
      n++;
    end while (i_usb_out_top.i_engine.state_q != StIdle && n < 200);
    if (n >= 200) begin
      tb_errors++;
      $display("Engine did not return to idle after a transaction");
    end
    step();
  endtask

  // One token, optional data packet, then compare handshake and toggles
  task automatic run_xact(input usb_pid_e tok, input logic [6:0] addr, input logic [3:0] ep,
                          input logic tog_ok, input int len, input logic with_data);
    logic accept;
    logic [6:0] exp;
    logic dtog;
    ep_idx_t idx;
    idx = ep_idx_t'(ep);
    accept = (addr == dev_m) && (ep < `USB_OUT_NUM_EPS) && en_m[idx] &&
             (tok == PidOut || (tok == PidSetup && ctl_m[idx]));
    if (accept && tok == PidSetup) tog_m[idx] = 1'b0;
    if (accept) setup_m[idx] = (tok == PidSetup);
    send_token(tok, addr, ep);
    dtog = accept ? tog_m[idx] : 1'b0;
    if (!tog_ok) dtog = ~dtog;
    exp = (accept && with_data) ?
          ref_response(tok == PidSetup, tog_ok, out_ep_full_i[idx], stall_m[idx]) : '0;
    if (with_data) send_data(dtog ? PidData1 : PidData0, len, accept);
    wait_idle();
    if (exp[1]) tog_m[idx] = ~tog_m[idx];
    i_checker.end_xact(accept, idx, exp[6], usb_pid_e'(exp[5:2]), exp[1], exp[0], setup_m);
    check_reg(5'h10, 32'(tog_m));
  endtask

  ////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(32'h430c116d));
    repeat (5) @(posedge clk_48mhz_i);
    #1 rst_ni = 1'b1;
    step();

    // Register access and masked toggle write
    dev_m = 7'h2a;
    en_m = 4'b0111;
    ctl_m = 4'b0001;
    stall_m = 4'b0100;
    axi_write(5'h00, 32'(dev_m));
    axi_write(5'h04, 32'(en_m));
    axi_write(5'h08, 32'(ctl_m));
    axi_write(5'h0C, 32'(stall_m));
    check_reg(5'h00, 32'(dev_m));
    check_reg(5'h04, 32'(en_m));
    check_reg(5'h08, 32'(ctl_m));
    check_reg(5'h0C, 32'(stall_m));
    // Full-mask write sets bits that the masked write must keep
    axi_write(5'h10, 32'h000f_0005);
    tog_m = 4'b0101;
    check_reg(5'h10, 32'(tog_m));
    // Mask 0011 loads bits 1 and 0 and keeps bits 3 and 2
    axi_write(5'h10, 32'h0003_000a);
    tog_m = 4'b0110;
    check_reg(5'h10, 32'(tog_m));
    axi_write(5'h10, 32'h000f_0000);
    tog_m = '0;
    check_reg(5'h10, 32'(tog_m));

    // Good OUT, then full, stalled and repeated packets
    run_xact(PidOut, dev_m, 4'd1, 1'b1, $urandom_range(1, 8), 1'b1);
    out_ep_full_i = 4'b0010;
    run_xact(PidOut, dev_m, 4'd1, 1'b1, 0, 1'b1);
    out_ep_full_i = '0;
    run_xact(PidOut, dev_m, 4'd2, 1'b1, $urandom_range(1, 8), 1'b1);
    run_xact(PidOut, dev_m, 4'd1, 1'b0, $urandom_range(1, 8), 1'b1);

    // SETUP handling and ignored tokens
    // OUT first so the SETUP has a set toggle to clear
    run_xact(PidOut, dev_m, 4'd0, 1'b1, $urandom_range(1, 8), 1'b1);
    run_xact(PidSetup, dev_m, 4'd0, 1'b1, 8, 1'b1);
    run_xact(PidOut, dev_m, 4'd0, 1'b1, $urandom_range(1, 8), 1'b1);
    run_xact(PidSetup, dev_m, 4'd1, 1'b1, 8, 1'b1);
    run_xact(PidOut, 7'h11, 4'd1, 1'b1, $urandom_range(1, 8), 1'b1);

    // Token without data, then normal traffic
    run_xact(PidOut, dev_m, 4'd1, 1'b1, 0, 1'b0);
    for (int i = 0; i < 6; i++) begin
      run_xact(PidOut, dev_m, 4'($urandom_range(0, 2)), 1'b1, $urandom_range(1, 8), 1'b1);
    end

    $display("Errors: %0d mismatches in checker, %0d in testbench", i_checker.errors, tb_errors);
    if (i_checker.errors == 0 && tb_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* verification/usb_out_checker.sv */
// Watches the endpoint and handshake outputs of the OUT engine
// The testbench queues expected puts and closes each transaction with its expectations

`timescale 1ns/1ps

module usb_out_checker import usb_out_pkg::*; (
  input logic       clk_48mhz_i,
  input logic       rst_ni,
  input logic       tx_pkt_start_i,
  input usb_pid_e   tx_pid_i,
  input logic       newpkt_i,
  input ep_idx_t    current_i,
  input logic       data_put_i,
  input put_addr_t  put_addr_i,
  input logic [7:0] data_i,
  input logic       acked_i,
  input logic       rollback_i,
  input ep_mask_t   setup_i
);

  int unsigned errors = 0;
  logic [12:0] put_q[$];
  int          n_tx = 0;
  int          n_new = 0;
  int          n_ack = 0;
  int          n_rb = 0;
  usb_pid_e    last_pid = PidAck;
  ep_idx_t     new_ep = '0;

  // Sample half a cycle after the edge, outputs are settled by then
  always @(negedge clk_48mhz_i) begin
    logic [12:0] exp;
    if (rst_ni) begin
      if (tx_pkt_start_i) begin
        n_tx++;
        last_pid = tx_pid_i;
      end
      // Current endpoint moves on the same edge as the newpkt pulse
      if (newpkt_i) begin
        n_new++;
        new_ep = current_i;
      end
      if (acked_i) n_ack++;
      if (rollback_i) n_rb++;
      if (data_put_i) begin
        if (put_q.size() == 0) begin
          errors++;
          $display("Mismatch at %0t: unexpected put at offset %0d", $time, put_addr_i);
        end else begin
          exp = put_q.pop_front();
          if ({put_addr_i, data_i} != exp) begin
            errors++;
            $display("Mismatch at %0t: put %0d/%02h, expected %0d/%02h", $time,
                     put_addr_i, data_i, exp[12:8], exp[7:0]);
          end
        end
      end
    end
  end

  task automatic push_put(input put_addr_t addr, input logic [7:0] data);
    put_q.push_back({addr, data});
  endtask

  task automatic compare_count(input string what, input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("Mismatch at %0t: %s count %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Close one transaction and compare what was seen against the reference
  task automatic end_xact(input logic exp_new, input ep_idx_t exp_ep, input logic exp_tx,
                          input usb_pid_e exp_pid, input logic exp_ack, input logic exp_rb,
                          input ep_mask_t exp_setup);
    compare_count("newpkt", n_new, exp_new);
    compare_count("tx_pkt_start", n_tx, exp_tx);
    compare_count("acked", n_ack, exp_ack);
    compare_count("rollback", n_rb, exp_rb);
    compare_count("missing put", put_q.size(), 0);
    if (exp_new && n_new == 1 && new_ep != exp_ep) begin
      errors++;
      $display("Mismatch at %0t: current endpoint %0d, expected %0d", $time, new_ep, exp_ep);
    end
    if (exp_tx && n_tx == 1 && last_pid != exp_pid) begin
      errors++;
      $display("Mismatch at %0t: tx pid %s, expected %s", $time, last_pid.name(), exp_pid.name());
    end
    if (setup_i != exp_setup) begin
      errors++;
      $display("Mismatch at %0t: setup mask %b, expected %b", $time, setup_i, exp_setup);
    end
    put_q.delete();
    n_tx = 0;
    n_new = 0;
    n_ack = 0;
    n_rb = 0;
  endtask

endmodule

/* verification/usb_out_props.sv */
// Concurrent checks on the OUT transaction engine
// Attached to every usb_out_xact_engine instance through bind

`timescale 1ns/1ps

module usb_out_props import usb_out_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input out_state_e state_i,
  input logic       tx_start_i,
  input logic       acked_i,
  input logic       rollback_i
);

  // Handshake only from the data end state, or the early ACK of a repeated packet
  tx_from_data_end: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_start_i |-> (state_i == StRcvdDataEnd || rollback_i))
    else $error("Handshake sent outside the data end state");

  ack_xor_rollback: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(acked_i && rollback_i))
    else $error("Acked and rollback pulsed together");

  legal_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i inside {StIdle, StRcvdOut, StRcvdDataStart, StRcvdDataEnd})
    else $error("Engine state holds an illegal value");

endmodule

bind usb_out_xact_engine usb_out_props i_props (
  .clk_i      (clk_48mhz_i),
  .rst_ni     (rst_ni),
  .state_i    (state_q),
  .tx_start_i (tx_pkt_start_o),
  .acked_i    (out_ep_acked_o),
  .rollback_i (out_ep_rollback_o)
);

/* logic/usb_out_top.sv */
// Top level of the USB OUT/SETUP engine
// Register block, transaction engine and data capture wired together

`timescale 1ns/1ps

module usb_out_top import usb_out_pkg::*; (
  input  logic        clk_48mhz_i,
  input  logic        rst_ni,
  input  logic        link_reset_i,
  // AXI4-Lite slave
  input  logic [4:0]  awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [31:0] wdata_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic [1:0]  bresp_o,
  output logic        bvalid_o,
  input  logic        bready_i,
  input  logic [4:0]  araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [31:0] rdata_o,
  output logic [1:0]  rresp_o,
  output logic        rvalid_o,
  input  logic        rready_i,
  // USB receive side
  input  logic        rx_pkt_start_i,
  input  logic        rx_pkt_end_i,
  input  logic        rx_pkt_valid_i,
  input  usb_pid_e    rx_pid_i,
  input  logic [6:0]  rx_addr_i,
  input  logic [3:0]  rx_endp_i,
  input  logic        rx_data_put_i,
  input  logic [7:0]  rx_data_i,
  // USB transmit side
  output logic        tx_pkt_start_o,
  output usb_pid_e    tx_pid_o,
  // Endpoint side
  output ep_idx_t     out_ep_current_o,
  output logic        out_ep_newpkt_o,
  output logic        out_ep_data_put_o,
  output put_addr_t   out_ep_put_addr_o,
  output logic [7:0]  out_ep_data_o,
  output logic        out_ep_acked_o,
  output logic        out_ep_rollback_o,
  output ep_mask_t    out_ep_setup_o,
  input  ep_mask_t    out_ep_full_i
);

  logic data_phase;
  logic xact_clear;
  logic nak;

  usb_out_cfg_if cfg ();

  usb_out_ep_regs i_regs (
    .clk_48mhz_i, .rst_ni,
    .awaddr_i, .awvalid_i, .awready_o,
    .wdata_i, .wvalid_i, .wready_o,
    .bresp_o, .bvalid_o, .bready_i,
    .araddr_i, .arvalid_i, .arready_o,
    .rdata_o, .rresp_o, .rvalid_o, .rready_i,
    .cfg (cfg.regs)
  );

  usb_out_xact_engine i_engine (
    .clk_48mhz_i, .rst_ni, .link_reset_i,
    .cfg (cfg.engine),
    .rx_pkt_start_i, .rx_pkt_end_i, .rx_pkt_valid_i,
    .rx_pid_i, .rx_addr_i, .rx_endp_i,
    .out_ep_full_i,
    .nak_i (nak),
    .tx_pkt_start_o, .tx_pid_o,
    .out_ep_current_o, .out_ep_newpkt_o,
    .out_ep_acked_o, .out_ep_rollback_o, .out_ep_setup_o,
    .data_phase_o (data_phase),
    .xact_clear_o (xact_clear)
  );

  // Full bit of the endpoint owning the transaction
  usb_out_rx_capture i_capture (
    .clk_48mhz_i, .rst_ni,
    .rx_data_put_i, .rx_data_i,
    .data_phase_i (data_phase),
    .xact_clear_i (xact_clear),
    .ep_full_i    (out_ep_full_i[out_ep_current_o]),
    .out_ep_data_put_o, .out_ep_put_addr_o, .out_ep_data_o,
    .nak_o        (nak)
  );

endmodule

/* logic/usb_out_rx_capture.sv */
// Data capture for the current OUT/SETUP transaction
// Latches received bytes, issues the delayed put strobe with its offset
// and remembers whether any byte hit a full endpoint

`timescale 1ns/1ps

module usb_out_rx_capture import usb_out_pkg::*; (
  input  logic      clk_48mhz_i,
  input  logic      rst_ni,
  input  logic      rx_data_put_i,
  input  logic [7:0] rx_data_i,
  input  logic      data_phase_i,
  input  logic      xact_clear_i,
  input  logic      ep_full_i,
  output logic      out_ep_data_put_o,
  output put_addr_t out_ep_put_addr_o,
  output logic [7:0] out_ep_data_o,
  output logic      nak_o
);

  logic advance;

  // Byte register, valid whenever the put strobe is high
  always_ff @(posedge clk_48mhz_i) begin
    if (rx_data_put_i) begin
      out_ep_data_o <= rx_data_i;
    end
  end

  // Stop counting once a NAK is pending or the offset is at its top
  assign advance = out_ep_data_put_o && !nak_o && !(&out_ep_put_addr_o);

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_data_put_o <= 1'b0;
      out_ep_put_addr_o <= '0;
      nak_o             <= 1'b0;
    end else begin
      // Put follows the rx strobe by one cycle
      out_ep_data_put_o <= data_phase_i && rx_data_put_i;
      if (xact_clear_i) begin
        out_ep_put_addr_o <= '0;
      end else if (data_phase_i && advance) begin
        out_ep_put_addr_o <= out_ep_put_addr_o + 1'b1;
      end
      // Sticky for the rest of the packet
      if (!data_phase_i) begin
        nak_o <= 1'b0;
      end else if (out_ep_data_put_o && ep_full_i) begin
        nak_o <= 1'b1;
      end
    end
  end

endmodule

/* logic/usb_out_xact_engine.sv */
// OUT/SETUP transaction engine
// Decodes tokens for this device, runs the transaction FSM with the data timeout,
// picks the handshake and keeps the per-endpoint data toggles

`timescale 1ns/1ps
`include "usb_out_settings.svh"

module usb_out_xact_engine import usb_out_pkg::*; (
  input  logic          clk_48mhz_i,
  input  logic          rst_ni,
  input  logic          link_reset_i,
  usb_out_cfg_if.engine cfg,
  input  logic          rx_pkt_start_i,
  input  logic          rx_pkt_end_i,
  input  logic          rx_pkt_valid_i,
  input  usb_pid_e      rx_pid_i,
  input  logic [6:0]    rx_addr_i,
  input  logic [3:0]    rx_endp_i,
  input  ep_mask_t      out_ep_full_i,
  input  logic          nak_i,
  output logic          tx_pkt_start_o,
  output usb_pid_e      tx_pid_o,
  output ep_idx_t       out_ep_current_o,
  output logic          out_ep_newpkt_o,
  output logic          out_ep_acked_o,
  output logic          out_ep_rollback_o,
  output ep_mask_t      out_ep_setup_o,
  output logic          data_phase_o,
  output logic          xact_clear_o
);

  localparam int unsigned TIMER_W = $clog2(`USB_OUT_ACK_TIMEOUT + 1);

  out_state_e         state_q, state_d;
  logic [TIMER_W-1:0] timer_q, timer_d;
  ep_mask_t           tog_q, tog_d;
  ep_idx_t            idx_d;
  logic token_rcvd, out_tok, setup_tok, tok_accept, xact_start;
  logic data_rcvd, bad_pkt, bad_toggle, setup_q, ep_full;

  //////////////////////////////////////////////////////////////////////
  // Token and packet decode
  //////////////////////////////////////////////////////////////////////
  // Token type is 2'b01 in the low PID bits
  assign token_rcvd = rx_pkt_end_i && rx_pkt_valid_i && (rx_pid_i[1:0] == 2'b01) &&
                      (rx_addr_i == cfg.dev_addr);
  assign out_tok    = token_rcvd && (rx_pid_i == PidOut);
  assign setup_tok  = token_rcvd && (rx_pid_i == PidSetup);
  assign idx_d      = rx_endp_i[$bits(ep_idx_t)-1:0];
  // Unimplemented or disabled endpoints are ignored, SETUP only on control
  assign tok_accept = (rx_endp_i < `USB_OUT_NUM_EPS) && cfg.ep_enabled[idx_d] &&
                      (out_tok || (setup_tok && cfg.ep_control[idx_d]));

  assign data_rcvd  = rx_pkt_end_i && rx_pkt_valid_i && (rx_pid_i inside {PidData0, PidData1});
  // Corrupt, or valid but not DATA0/DATA1
  assign bad_pkt    = rx_pkt_end_i && !data_rcvd;
  // PID bit 3 carries the DATA0/DATA1 toggle
  assign bad_toggle = data_rcvd && (rx_pid_i[3] != tog_q[out_ep_current_o]);
  assign ep_full    = out_ep_full_i[out_ep_current_o];

  //////////////////////////////////////////////////////////////////////
  // Transaction FSM
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    state_d           = state_q;
    timer_d           = TIMER_W'(`USB_OUT_ACK_TIMEOUT);
    xact_start        = 1'b0;
    tx_pkt_start_o    = 1'b0;
    tx_pid_o          = PidAck;
    out_ep_acked_o    = 1'b0;
    out_ep_rollback_o = 1'b0;
    case (state_q)
      StIdle: begin
        if (tok_accept) begin
          state_d    = StRcvdOut;
          xact_start = 1'b1;
        end
      end
      StRcvdOut: begin
        // Host gets a bounded window to start the data packet
        timer_d = timer_q - 1'b1;
        if (rx_pkt_start_i) begin
          state_d = StRcvdDataStart;
        end else if (timer_q == '0) begin
          state_d = StIdle;
        end
      end
      StRcvdDataStart: begin
        if (bad_toggle && !cfg.ep_stall[out_ep_current_o]) begin
          // Host likely missed our last ACK, ACK again and drop the data
          state_d           = StIdle;
          out_ep_rollback_o = 1'b1;
          tx_pkt_start_o    = 1'b1;
        end else if (bad_pkt) begin
          // Silent drop, no NAK on a bad CRC
          state_d           = StIdle;
          out_ep_rollback_o = 1'b1;
        end else if (data_rcvd) begin
          state_d = StRcvdDataEnd;
        end
      end
      StRcvdDataEnd: begin
        state_d        = StIdle;
        tx_pkt_start_o = 1'b1;
        if (setup_q) begin
          // A SETUP that could not be stored gets no answer at all
          if (nak_i || ep_full) begin
            tx_pkt_start_o    = 1'b0;
            out_ep_rollback_o = 1'b1;
          end else begin
            out_ep_acked_o = 1'b1;
          end
        end else if (cfg.ep_stall[out_ep_current_o]) begin
          tx_pid_o = PidStall;
        end else if (nak_i || ep_full) begin
          tx_pid_o          = PidNak;
          out_ep_rollback_o = 1'b1;
        end else begin
          out_ep_acked_o = 1'b1;
        end
      end
      default: state_d = StIdle;
    endcase
    // Link reset aborts everything and keeps pulses quiet
    if (link_reset_i) begin
      state_d           = StIdle;
      xact_start        = 1'b0;
      tx_pkt_start_o    = 1'b0;
      out_ep_acked_o    = 1'b0;
      out_ep_rollback_o = 1'b0;
    end
  end

  assign data_phase_o = (state_q == StRcvdDataStart);
  assign xact_clear_o = (state_q == StRcvdOut);

  // Toggle update, then software writes on top through the mask
  always_comb begin
    tog_d = tog_q;
    if (xact_start && setup_tok) begin
      tog_d[idx_d] = 1'b0;
    end else if (out_ep_acked_o) begin
      tog_d[out_ep_current_o] = ~tog_q[out_ep_current_o];
    end
    if (cfg.tog_we) begin
      tog_d = (tog_d & ~cfg.tog_mask) | (cfg.tog_status & cfg.tog_mask);
    end
  end
  assign cfg.data_toggle = tog_q;

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= StIdle;
      timer_q          <= TIMER_W'(`USB_OUT_ACK_TIMEOUT);
      tog_q            <= '0;
      out_ep_setup_o   <= '0;
      out_ep_newpkt_o  <= 1'b0;
      out_ep_current_o <= '0;
      setup_q          <= 1'b0;
    end else begin
      state_q         <= state_d;
      timer_q         <= timer_d;
      tog_q           <= link_reset_i ? '0 : tog_d;
      out_ep_newpkt_o <= xact_start;
      if (link_reset_i) begin
        out_ep_setup_o <= '0;
      end else if (xact_start) begin
        // SETUP marks the endpoint, a later OUT clears it
        out_ep_setup_o[idx_d] <= setup_tok;
        out_ep_current_o      <= idx_d;
        setup_q               <= setup_tok;
      end
    end
  end

endmodule

/* logic/usb_out_ep_regs.sv */
// AXI4-Lite register block for the OUT engine
// Holds device address and endpoint masks, turns toggle writes into a strobe

`timescale 1ns/1ps

module usb_out_ep_regs import usb_out_pkg::*; (
  input  logic        clk_48mhz_i,
  input  logic        rst_ni,
  input  logic [4:0]  awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [31:0] wdata_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic [1:0]  bresp_o,
  output logic        bvalid_o,
  input  logic        bready_i,
  input  logic [4:0]  araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [31:0] rdata_o,
  output logic [1:0]  rresp_o,
  output logic        rvalid_o,
  input  logic        rready_i,
  usb_out_cfg_if.regs cfg
);

  localparam int unsigned NEP = $bits(ep_mask_t);

  logic        wr_fire;
  logic        rd_fire;
  logic [31:0] rd_mux;

  // Address and data are taken together, one write in flight
  assign wr_fire   = awvalid_i && wvalid_i && !bvalid_o;
  assign awready_o = wr_fire;
  assign wready_o  = wr_fire;
  assign rd_fire   = arvalid_i && !rvalid_o;
  assign arready_o = rd_fire;
  // Always OKAY
  assign bresp_o = 2'b00;
  assign rresp_o = 2'b00;

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg.dev_addr   <= '0;
      cfg.ep_enabled <= '0;
      cfg.ep_control <= '0;
      cfg.ep_stall   <= '0;
      cfg.tog_we     <= 1'b0;
      bvalid_o       <= 1'b0;
      rvalid_o       <= 1'b0;
    end else begin
      // Toggle strobe lives for one cycle only
      cfg.tog_we <= wr_fire && (awaddr_i == 5'h10);
      if (wr_fire) begin
        case (awaddr_i)
          5'h00:   cfg.dev_addr   <= wdata_i[6:0];
          5'h04:   cfg.ep_enabled <= wdata_i[NEP-1:0];
          5'h08:   cfg.ep_control <= wdata_i[NEP-1:0];
          5'h0C:   cfg.ep_stall   <= wdata_i[NEP-1:0];
          default: ;
        endcase
      end
      // Write response holds until accepted
      if (wr_fire) begin
        bvalid_o <= 1'b1;
      end else if (bready_i) begin
        bvalid_o <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_o <= 1'b1;
      end else if (rready_i) begin
        rvalid_o <= 1'b0;
      end
    end
  end

  // Toggle value in the low bits, select mask from bit 16 up
  always_ff @(posedge clk_48mhz_i) begin
    if (wr_fire) begin
      cfg.tog_status <= wdata_i[NEP-1:0];
      cfg.tog_mask   <= wdata_i[16 +: NEP];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    rd_mux = '0;
    case (araddr_i)
      5'h00:   rd_mux[6:0]     = cfg.dev_addr;
      5'h04:   rd_mux[NEP-1:0] = cfg.ep_enabled;
      5'h08:   rd_mux[NEP-1:0] = cfg.ep_control;
      5'h0C:   rd_mux[NEP-1:0] = cfg.ep_stall;
      // Live toggles straight from the engine
      5'h10:   rd_mux[NEP-1:0] = cfg.data_toggle;
      default: rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_48mhz_i) begin
    if (rd_fire) begin
      rdata_o <= rd_mux;
    end
  end

endmodule

/* logic/usb_out_cfg_if.sv */
// Configuration bundle from the AXI4-Lite register block to the OUT engine
// Also returns the live data toggles for software reads

`timescale 1ns/1ps

interface usb_out_cfg_if import usb_out_pkg::*; ();
  logic [6:0] dev_addr;
  ep_mask_t   ep_enabled;
  ep_mask_t   ep_control;
  ep_mask_t   ep_stall;
  // Software toggle write, one-cycle strobe with value and select mask
  logic       tog_we;
  ep_mask_t   tog_status;
  ep_mask_t   tog_mask;
  // Current toggle state from the engine
  ep_mask_t   data_toggle;

  modport regs (output dev_addr, ep_enabled, ep_control, ep_stall,
                output tog_we, tog_status, tog_mask, input data_toggle);
  modport engine (input dev_addr, ep_enabled, ep_control, ep_stall,
                  input tog_we, tog_status, tog_mask, output data_toggle);
endinterface

/* logic/usb_out_pkg.sv */
// Types shared by the OUT/SETUP engine, its register block and the capture path
// Modules pull these in with a wildcard import in their header

`include "usb_out_settings.svh"

package usb_out_pkg;

  // Packet IDs seen or sent by the OUT side
  // Low two bits are the PID type, 2'b01 marks a token
  typedef enum logic [3:0] {
    PidOut   = 4'b0001,
    PidSetup = 4'b1101,
    PidData0 = 4'b0011,
    PidData1 = 4'b1011,
    PidAck   = 4'b0010,
    PidNak   = 4'b1010,
    PidStall = 4'b1110
  } usb_pid_e;

  // One bit per implemented endpoint
  typedef logic [`USB_OUT_NUM_EPS-1:0] ep_mask_t;
  typedef logic [$clog2(`USB_OUT_NUM_EPS)-1:0] ep_idx_t;

  // Byte offset inside one packet
  typedef logic [$clog2(`USB_OUT_MAX_PKT)-1:0] put_addr_t;

  // Transaction FSM
  typedef enum logic [1:0] {
    StIdle,
    StRcvdOut,
    StRcvdDataStart,
    StRcvdDataEnd
  } out_state_e;

endpackage

/* logic/usb_out_settings.svh */
// Build-time sizing for the USB OUT/SETUP protocol engine
// Included by the package and by any module that needs the raw numbers

`ifndef USB_OUT_SETTINGS_SVH
`define USB_OUT_SETTINGS_SVH

// Implemented OUT endpoints, 0 up to this count minus one
`define USB_OUT_NUM_EPS 4

// Largest data payload in bytes, sets the put offset width
`define USB_OUT_MAX_PKT 32

// 48 MHz cycles to wait for the host data packet after a token
`define USB_OUT_ACK_TIMEOUT 68

`endif
